//--- hw/auto_mode_controller.sv
// Top level of the altitude auto-mode controller that joins the sequencer, qualifier and FSM
`default_nettype none

module auto_mode_controller #(
    parameter int unsigned climb_steps = 10  // Updates held in climb and descend
) (
    input  wire                        us_clk,
    input  wire                        resetn,
    input  wire                        imu_good,
    input  wire                        start_signal,
    input  wire flight_pkg::throttle_t throttle_pwm_val_in,
    input  wire flight_pkg::switch_a_t switch_a,
    input  wire flight_pkg::switch_b_t switch_b,
    input  wire flight_pkg::velocity_t z_linear_velocity,
    output wire flight_pkg::throttle_t throttle_pwm_val_out,
    output wire                        active_signal,
    output wire                        complete_signal,
    output wire                        in_air,
    output wire flight_pkg::flight_mode_t mode
);

    wire                        sample_strobe;
    wire                        step_strobe;
    wire                        throttle_off;
    wire                        still;
    wire                        auto_sel;
    wire                        up_req;
    wire                        down_req;
    wire flight_pkg::throttle_t pilot_throttle;

    update_sequencer u_sequencer (
        .us_clk          (us_clk),
        .resetn          (resetn),
        .imu_good        (imu_good),
        .start_signal    (start_signal),
        .sample_strobe   (sample_strobe),
        .step_strobe     (step_strobe),
        .active_signal   (active_signal),
        .complete_signal (complete_signal)
    );

    sample_qualifier u_qualifier (
        .us_clk              (us_clk),
        .resetn              (resetn),
        .sample_strobe       (sample_strobe),
        .throttle_pwm_val_in (throttle_pwm_val_in),
        .switch_a            (switch_a),
        .switch_b            (switch_b),
        .z_linear_velocity   (z_linear_velocity),
        .throttle_off        (throttle_off),
        .still               (still),
        .auto_sel            (auto_sel),
        .up_req              (up_req),
        .down_req            (down_req),
        .pilot_throttle      (pilot_throttle)
    );

    // Conditions are registered at the end of latch and consumed in step
    flight_mode_fsm #(
        .climb_steps (climb_steps)
    ) u_mode_fsm (
        .us_clk               (us_clk),
        .resetn               (resetn),
        .step_strobe          (step_strobe),
        .throttle_off         (throttle_off),
        .still                (still),
        .auto_sel             (auto_sel),
        .up_req               (up_req),
        .down_req             (down_req),
        .pilot_throttle       (pilot_throttle),
        .mode                 (mode),
        .in_air               (in_air),
        .throttle_pwm_val_out (throttle_pwm_val_out)
    );

endmodule

`default_nettype wire

//--- hw/flight_mode_fsm.sv
// Nine-state flight mode machine that advances one step per update and drives the throttle command
`default_nettype none

module flight_mode_fsm #(
    parameter int unsigned climb_steps = 10
) (
    input  wire                        us_clk,
    input  wire                        resetn,
    input  wire                        step_strobe,
    input  wire                        throttle_off,
    input  wire                        still,
    input  wire                        auto_sel,
    input  wire                        up_req,
    input  wire                        down_req,
    input  wire flight_pkg::throttle_t pilot_throttle,
    output flight_pkg::flight_mode_t   mode,
    output logic                       in_air,
    output flight_pkg::throttle_t      throttle_pwm_val_out
);

    // Updates spent in climbing or descending after the start state
    localparam logic [flight_pkg::HOLD_WIDTH-1:0] hold_load =
        climb_steps[flight_pkg::HOLD_WIDTH-1:0];

    logic [flight_pkg::HOLD_WIDTH-1:0] hold_cnt;
    logic [flight_pkg::HOLD_WIDTH-1:0] next_hold_cnt;
    flight_pkg::flight_mode_t          next_mode;
    logic                              next_in_air;
    flight_pkg::throttle_t             next_throttle;

    // Transition rules, first match wins
    always_comb begin
        next_mode     = mode;
        next_hold_cnt = hold_cnt;
        unique case (mode)
            flight_pkg::MODE_FAILSAFE: begin
                if (!throttle_off) begin
                    next_mode = flight_pkg::MODE_ON_GROUND;
                end
            end
            flight_pkg::MODE_ON_GROUND: begin
                if (throttle_off) begin
                    next_mode = flight_pkg::MODE_FAILSAFE;
                end else if (up_req) begin
                    next_mode = flight_pkg::MODE_UP_START;
                end else if (!auto_sel) begin
                    next_mode = flight_pkg::MODE_MANUAL;
                end else if (still) begin
                    next_mode = flight_pkg::MODE_GROUND_IDLE;  // Landed so the throttle is cut
                end
            end
            flight_pkg::MODE_GROUND_IDLE: begin
                if (throttle_off) begin
                    next_mode = flight_pkg::MODE_FAILSAFE;
                end else if (!auto_sel) begin
                    next_mode = flight_pkg::MODE_MANUAL;
                end
            end
            flight_pkg::MODE_UP_START: begin
                next_hold_cnt = hold_load;
                next_mode     = flight_pkg::MODE_GO_UP;
            end
            flight_pkg::MODE_DOWN_START: begin
                next_hold_cnt = hold_load;
                next_mode     = flight_pkg::MODE_GO_DOWN;
            end
            flight_pkg::MODE_GO_UP: begin
                if (throttle_off) begin
                    next_mode = flight_pkg::MODE_FAILSAFE;
                end else if (!auto_sel) begin
                    next_mode = flight_pkg::MODE_MANUAL;
                end else if (hold_cnt != '0) begin
                    next_hold_cnt = hold_cnt - 1'b1;  // Keep climbing
                end else begin
                    next_mode = flight_pkg::MODE_IN_AIR;
                end
            end
            flight_pkg::MODE_GO_DOWN: begin
                if (throttle_off) begin
                    next_mode = flight_pkg::MODE_FAILSAFE;
                end else if (!auto_sel) begin
                    next_mode = flight_pkg::MODE_MANUAL;
                end else if (hold_cnt != '0) begin
                    next_hold_cnt = hold_cnt - 1'b1;
                end else begin
                    next_mode = flight_pkg::MODE_ON_GROUND;
                end
            end
            flight_pkg::MODE_IN_AIR: begin
                if (throttle_off) begin
                    next_mode = flight_pkg::MODE_FAILSAFE;
                end else if (down_req) begin
                    next_mode = flight_pkg::MODE_DOWN_START;
                end else if (!auto_sel) begin
                    next_mode = flight_pkg::MODE_MANUAL;
                end
            end
            flight_pkg::MODE_MANUAL: begin
                // Handing back to auto assumes the drone is airborne
                if (auto_sel) begin
                    next_mode = flight_pkg::MODE_IN_AIR;
                end
            end
            default: begin
                next_mode = flight_pkg::MODE_FAILSAFE;
            end
        endcase
    end

    // Flag and throttle follow the mode being entered
    always_comb begin
        next_in_air   = in_air;
        next_throttle = throttle_pwm_val_out;
        unique case (next_mode)
            flight_pkg::MODE_FAILSAFE: begin
                next_in_air   = 1'b0;
                next_throttle = '0;
            end
            flight_pkg::MODE_GROUND_IDLE: begin
                next_in_air   = 1'b0;
                next_throttle = '0;
            end
            flight_pkg::MODE_ON_GROUND: begin
                next_throttle = flight_pkg::LEVEL_GROUND;  // In-air flag holds until still
            end
            flight_pkg::MODE_UP_START,
            flight_pkg::MODE_DOWN_START: begin
                next_in_air = 1'b1;  // Throttle holds for one update
            end
            flight_pkg::MODE_GO_UP: begin
                next_throttle = flight_pkg::LEVEL_CLIMB;
            end
            flight_pkg::MODE_GO_DOWN: begin
                next_throttle = flight_pkg::LEVEL_DESCEND;
            end
            flight_pkg::MODE_IN_AIR: begin
                next_in_air   = 1'b1;
                next_throttle = flight_pkg::LEVEL_HOVER;
            end
            flight_pkg::MODE_MANUAL: begin
                next_throttle = pilot_throttle;
            end
            default: begin
                next_in_air   = 1'b0;
                next_throttle = '0;
            end
        endcase
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            mode                 <= flight_pkg::MODE_FAILSAFE;
            hold_cnt             <= '0;
            in_air               <= 1'b0;
            throttle_pwm_val_out <= '0;
        end else if (step_strobe) begin
            mode                 <= next_mode;
            hold_cnt             <= next_hold_cnt;
            in_air               <= next_in_air;
            throttle_pwm_val_out <= next_throttle;
        end
    end

endmodule

`default_nettype wire

//--- hw/flight_pkg.sv
// Shared types, limits and throttle levels for the altitude auto-mode controller and its testbench
`default_nettype none

package flight_pkg;

    // Pilot or commanded throttle value
    typedef logic [7:0] throttle_t;

    // Vertical velocity from the IMU with positive up
    typedef logic signed [15:0] velocity_t;

    typedef logic [2:0] switch_a_t;  // Mode switch
    typedef logic [1:0] switch_b_t;  // Direction switch

    // Switch bit positions
    localparam int SWITCH_A_AUTO = 1;  // Auto mode selected
    localparam int SWITCH_B_UP   = 0;  // Climb requested
    localparam int SWITCH_B_DOWN = 1;  // Descent requested

    // Throttle below this reads as throttle off or radio lost
    localparam throttle_t THROTTLE_OFF_LIMIT = 8'd10;

    // Velocity strictly inside +/- this band counts as still
    localparam velocity_t STILL_LIMIT = 16'sd10;

    // Commanded throttle for each automatic phase
    localparam throttle_t LEVEL_GROUND  = 8'd15;
    localparam throttle_t LEVEL_CLIMB   = 8'd25;
    localparam throttle_t LEVEL_DESCEND = 8'd20;
    localparam throttle_t LEVEL_HOVER   = 8'd30;

    // Hold counter width for the climb and descend phases
    localparam int HOLD_WIDTH = 16;

    // One-hot flight mode, also published as the mode output
    typedef enum logic [8:0] {
        MODE_FAILSAFE    = 9'b0_0000_0001,
        MODE_ON_GROUND   = 9'b0_0000_0010,
        MODE_GROUND_IDLE = 9'b0_0000_0100,  // On ground with throttle cut
        MODE_UP_START    = 9'b0_0000_1000,
        MODE_DOWN_START  = 9'b0_0001_0000,
        MODE_GO_UP       = 9'b0_0010_0000,
        MODE_GO_DOWN     = 9'b0_0100_0000,
        MODE_IN_AIR      = 9'b0_1000_0000,
        MODE_MANUAL      = 9'b1_0000_0000   // Pilot has direct throttle
    } flight_mode_t;

endpackage

`default_nettype wire

//--- hw/sample_qualifier.sv
// Captures pilot and IMU inputs on the sample strobe and derives the mode machine's conditions
`default_nettype none

module sample_qualifier (
    input  wire                   us_clk,
    input  wire                   resetn,
    input  wire                   sample_strobe,
    input  wire flight_pkg::throttle_t throttle_pwm_val_in,
    input  wire flight_pkg::switch_a_t switch_a,
    input  wire flight_pkg::switch_b_t switch_b,
    input  wire flight_pkg::velocity_t z_linear_velocity,
    output logic                  throttle_off,
    output logic                  still,
    output logic                  auto_sel,
    output logic                  up_req,
    output logic                  down_req,
    output flight_pkg::throttle_t pilot_throttle
);

    flight_pkg::throttle_t throttle_q;
    flight_pkg::velocity_t velocity_q;
    flight_pkg::switch_a_t switch_a_q;
    flight_pkg::switch_b_t switch_b_q;

    // One snapshot per update request
    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            throttle_q <= '0;
            velocity_q <= '0;
            switch_a_q <= '0;
            switch_b_q <= '0;
        end else if (sample_strobe) begin
            throttle_q <= throttle_pwm_val_in;
            velocity_q <= z_linear_velocity;
            switch_a_q <= switch_a;
            switch_b_q <= switch_b;
        end
    end

    assign throttle_off = (throttle_q < flight_pkg::THROTTLE_OFF_LIMIT);

    // Signed compare against the still band
    assign still = (velocity_q < flight_pkg::STILL_LIMIT) &&
                   (velocity_q > -flight_pkg::STILL_LIMIT);

    assign auto_sel = switch_a_q[flight_pkg::SWITCH_A_AUTO];
    assign up_req   = auto_sel && switch_b_q[flight_pkg::SWITCH_B_UP];
    assign down_req = auto_sel && switch_b_q[flight_pkg::SWITCH_B_DOWN];

    assign pilot_throttle = throttle_q;  // Passed on for manual mode

endmodule

`default_nettype wire

//--- hw/update_sequencer.sv
// Request sequencer that turns each start pulse into a sample strobe, a step strobe and a complete
`default_nettype none

module update_sequencer (
    input  wire  us_clk,
    input  wire  resetn,
    input  wire  imu_good,
    input  wire  start_signal,
    output logic sample_strobe,
    output logic step_strobe,
    output logic active_signal,
    output logic complete_signal
);

    typedef enum logic [4:0] {
        st_init     = 5'b00001,
        st_wait     = 5'b00010,
        st_latch    = 5'b00100,
        st_step     = 5'b01000,
        st_complete = 5'b10000
    } seq_state_t;

    seq_state_t state;
    seq_state_t next_state;
    logic       start_flag;  // Pending request

    // Holds a request until the latch state sees start low again
    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            start_flag <= 1'b0;
        end else if (start_signal && !start_flag) begin
            start_flag <= 1'b1;
        end else if (!start_signal && start_flag && (state == st_latch)) begin
            start_flag <= 1'b0;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            st_init: begin
                if (imu_good) begin
                    next_state = st_wait;  // IMU is up so requests are accepted
                end
            end
            st_wait: begin
                if (start_flag) begin
                    next_state = st_latch;
                end
            end
            st_latch:    next_state = st_step;
            st_step:     next_state = st_complete;
            st_complete: next_state = st_wait;
            default:     next_state = st_init;
        endcase
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            state           <= st_init;
            active_signal   <= 1'b0;
            complete_signal <= 1'b0;
        end else begin
            state           <= next_state;
            // Decoded from the next state so the flags line up with the state itself
            active_signal   <= (next_state == st_latch) || (next_state == st_step);
            complete_signal <= (next_state == st_complete);
        end
    end

    // Sample in latch, advance the mode machine in step
    assign sample_strobe = (state == st_latch);
    assign step_strobe   = (state == st_step);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the auto-mode controller testbench with Verilator and run it
# The exit status is nonzero when the build or the simulation fails
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_auto_mode -f sources.f -o sim_auto_mode &&
./obj_dir/sim_auto_mode ||
{ echo "build or simulation failed"; exit 1; }
exit 0

//--- sim/tb_auto_mode.sv
// Testbench for the auto-mode controller with directed flights and LFSR updates against a model
`default_nettype none

module tb_auto_mode;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int unsigned CLIMB_STEPS = 3;
    localparam int TIMEOUT_CYCLES = 20;  // Per wait loop
    localparam int IDLE_WINDOW    = 20;
    localparam int RANDOM_UPDATES = 200;

    localparam flight_pkg::switch_a_t SA_AUTO   = 3'b010;
    localparam flight_pkg::switch_a_t SA_MANUAL = 3'b101;  // Auto bit clear
    localparam flight_pkg::switch_b_t SB_NONE   = 2'b00;
    localparam flight_pkg::switch_b_t SB_UP     = 2'b01;
    localparam flight_pkg::switch_b_t SB_DOWN   = 2'b10;

    typedef struct packed {
        flight_pkg::flight_mode_t          mode;
        logic                              in_air;
        flight_pkg::throttle_t             throttle;
        logic [flight_pkg::HOLD_WIDTH-1:0] hold;
    } model_t;

    logic                     us_clk;
    logic                     resetn;
    logic                     imu_good;
    logic                     start_signal;
    flight_pkg::throttle_t    throttle_pwm_val_in;
    flight_pkg::switch_a_t    switch_a;
    flight_pkg::switch_b_t    switch_b;
    flight_pkg::velocity_t    z_linear_velocity;
    flight_pkg::throttle_t    throttle_pwm_val_out;
    logic                     active_signal;
    logic                     complete_signal;
    logic                     in_air;
    flight_pkg::flight_mode_t mode;

    model_t      expected;
    logic [31:0] lfsr_state = 32'h0f54_1be0;
    int          complete_count = 0;

    auto_mode_controller #(
        .climb_steps (CLIMB_STEPS)
    ) uut (
        .us_clk               (us_clk),
        .resetn               (resetn),
        .imu_good             (imu_good),
        .start_signal         (start_signal),
        .throttle_pwm_val_in  (throttle_pwm_val_in),
        .switch_a             (switch_a),
        .switch_b             (switch_b),
        .z_linear_velocity    (z_linear_velocity),
        .throttle_pwm_val_out (throttle_pwm_val_out),
        .active_signal        (active_signal),
        .complete_signal      (complete_signal),
        .in_air               (in_air),
        .mode                 (mode)
    );

    initial begin
        us_clk = 1'b0;
        forever #20 us_clk = ~us_clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[14:0], lfsr_state[0]};  // One step per bit
        end
        return value;
    endfunction

    // Next mode, flag, throttle and hold count for one update
    function automatic model_t predict(input model_t prev, input flight_pkg::throttle_t thr,
                                       input flight_pkg::velocity_t vel,
                                       input flight_pkg::switch_a_t sa,
                                       input flight_pkg::switch_b_t sb);
        model_t nxt;
        logic   thr_off;
        logic   is_still;
        logic   auto_on;
        logic   go_up;
        logic   go_down;
        nxt      = prev;
        thr_off  = thr < flight_pkg::THROTTLE_OFF_LIMIT;
        is_still = (vel < flight_pkg::STILL_LIMIT) && (vel > -flight_pkg::STILL_LIMIT);
        auto_on  = sa[flight_pkg::SWITCH_A_AUTO];
        go_up    = auto_on && sb[flight_pkg::SWITCH_B_UP];
        go_down  = auto_on && sb[flight_pkg::SWITCH_B_DOWN];
        case (prev.mode)
            flight_pkg::MODE_FAILSAFE: begin
                if (!thr_off) nxt.mode = flight_pkg::MODE_ON_GROUND;
            end
            flight_pkg::MODE_ON_GROUND: begin
                if (thr_off) nxt.mode = flight_pkg::MODE_FAILSAFE;
                else if (go_up) nxt.mode = flight_pkg::MODE_UP_START;
                else if (!auto_on) nxt.mode = flight_pkg::MODE_MANUAL;
                else if (is_still) nxt.mode = flight_pkg::MODE_GROUND_IDLE;
            end
            flight_pkg::MODE_GROUND_IDLE: begin
                if (thr_off) nxt.mode = flight_pkg::MODE_FAILSAFE;
                else if (!auto_on) nxt.mode = flight_pkg::MODE_MANUAL;
            end
            flight_pkg::MODE_UP_START, flight_pkg::MODE_DOWN_START: begin
                nxt.hold = 16'(CLIMB_STEPS);
                nxt.mode = (prev.mode == flight_pkg::MODE_UP_START) ?
                           flight_pkg::MODE_GO_UP : flight_pkg::MODE_GO_DOWN;
            end
            flight_pkg::MODE_GO_UP, flight_pkg::MODE_GO_DOWN: begin
                if (thr_off) nxt.mode = flight_pkg::MODE_FAILSAFE;
                else if (!auto_on) nxt.mode = flight_pkg::MODE_MANUAL;
                else if (prev.hold != 16'd0) nxt.hold = prev.hold - 16'd1;
                else nxt.mode = (prev.mode == flight_pkg::MODE_GO_UP) ?
                                flight_pkg::MODE_IN_AIR : flight_pkg::MODE_ON_GROUND;
            end
            flight_pkg::MODE_IN_AIR: begin
                if (thr_off) nxt.mode = flight_pkg::MODE_FAILSAFE;
                else if (go_down) nxt.mode = flight_pkg::MODE_DOWN_START;
                else if (!auto_on) nxt.mode = flight_pkg::MODE_MANUAL;
            end
            flight_pkg::MODE_MANUAL: begin
                if (auto_on) nxt.mode = flight_pkg::MODE_IN_AIR;
            end
            default: nxt.mode = flight_pkg::MODE_FAILSAFE;
        endcase
        // Outputs follow the entered mode
        case (nxt.mode)
            flight_pkg::MODE_FAILSAFE, flight_pkg::MODE_GROUND_IDLE: begin
                nxt.in_air   = 1'b0;
                nxt.throttle = '0;
            end
            flight_pkg::MODE_ON_GROUND:  nxt.throttle = flight_pkg::LEVEL_GROUND;
            flight_pkg::MODE_UP_START, flight_pkg::MODE_DOWN_START: nxt.in_air = 1'b1;
            flight_pkg::MODE_GO_UP:      nxt.throttle = flight_pkg::LEVEL_CLIMB;
            flight_pkg::MODE_GO_DOWN:    nxt.throttle = flight_pkg::LEVEL_DESCEND;
            flight_pkg::MODE_IN_AIR: begin
                nxt.in_air   = 1'b1;
                nxt.throttle = flight_pkg::LEVEL_HOVER;
            end
            flight_pkg::MODE_MANUAL:     nxt.throttle = thr;
            default: begin
            end
        endcase
        return nxt;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] want);
        if (actual !== want) begin
            report_failure($sformatf("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                                     $time, name, actual, want));
        end
    endtask

    // Compare every completed update with the model
    always @(negedge us_clk) begin
        if (complete_signal) begin
            complete_count = complete_count + 1;
            check_value("mode", 32'(mode), 32'(expected.mode));
            check_value("in_air", 32'(in_air), 32'(expected.in_air));
            check_value("throttle_pwm_val_out", 32'(throttle_pwm_val_out),
                        32'(expected.throttle));
        end
    end

    task automatic apply_reset();
        @(negedge us_clk);
        resetn = 1'b0;
        expected = '{flight_pkg::MODE_FAILSAFE, 1'b0, 8'd0, 16'd0};
        repeat (2) @(negedge us_clk);
        resetn = 1'b1;
    endtask

    // Called on a falling edge and returns on the falling edge after complete
    task automatic run_request();
        int waited;
        int active_cycles;
        int count_before;
        count_before = complete_count;
        start_signal = 1'b1;
        @(negedge us_clk);
        start_signal = 1'b0;
        waited = 0;
        while (!active_signal && waited < TIMEOUT_CYCLES) begin
            @(negedge us_clk);
            waited++;
        end
        if (!active_signal) report_failure("active_signal never rose after a start pulse");
        active_cycles = 0;
        waited = 0;
        while (!complete_signal && waited < TIMEOUT_CYCLES) begin
            if (active_signal) active_cycles++;
            @(negedge us_clk);
            waited++;
        end
        if (!complete_signal) report_failure("complete_signal never rose after active_signal");
        @(negedge us_clk);
        check_value("active cycles", 32'(active_cycles), 32'd2);
        check_value("complete pulses", 32'(complete_count - count_before), 32'd1);
        check_value("complete_signal", 32'(complete_signal), 32'd0);  // One cycle wide
    endtask

    task automatic run_update(input flight_pkg::throttle_t thr, input flight_pkg::velocity_t vel,
                              input flight_pkg::switch_a_t sa, input flight_pkg::switch_b_t sb);
        @(negedge us_clk);
        throttle_pwm_val_in = thr;
        z_linear_velocity   = vel;
        switch_a            = sa;
        switch_b            = sb;
        expected = predict(expected, thr, vel, sa, sb);
        run_request();
    endtask

    task automatic expect_mode(input flight_pkg::flight_mode_t want);
        check_value("mode", 32'(mode), 32'(want));
    endtask

    task automatic check_no_complete();
        int waited;
        waited = 0;
        @(negedge us_clk);
        start_signal = 1'b1;
        @(negedge us_clk);
        start_signal = 1'b0;
        while (waited < IDLE_WINDOW && !complete_signal && !active_signal) begin
            @(negedge us_clk);
            waited++;
        end
        if (complete_signal || active_signal) begin
            report_failure("an update ran while imu_good was low, no complete expected");
        end
    endtask

    initial begin
        flight_pkg::throttle_t manual_levels [4];
        flight_pkg::throttle_t thr;
        flight_pkg::velocity_t vel;
        manual_levels = '{8'd40, 8'd77, 8'd5, 8'd200};
        resetn = 1'b0;
        imu_good = 1'b0;
        start_signal = 1'b0;
        throttle_pwm_val_in = '0;
        switch_a = '0;
        switch_b = '0;
        z_linear_velocity = '0;
        apply_reset();

        // Reset values and no update without the IMU
        check_value("throttle_pwm_val_out", 32'(throttle_pwm_val_out), 32'd0);
        check_value("mode", 32'(mode), 32'(flight_pkg::MODE_FAILSAFE));
        check_value("in_air", 32'(in_air), 32'd0);
        check_value("active_signal", 32'(active_signal), 32'd0);
        check_value("complete_signal", 32'(complete_signal), 32'd0);
        check_no_complete();
        apply_reset();  // Drops the start flag left pending
        @(negedge us_clk);
        imu_good = 1'b1;

        // Climb out, hover, descend and land
        run_update(8'd100, 16'sd50, SA_AUTO, SB_UP);
        expect_mode(flight_pkg::MODE_ON_GROUND);
        run_update(8'd100, 16'sd50, SA_AUTO, SB_UP);
        expect_mode(flight_pkg::MODE_UP_START);
        repeat (CLIMB_STEPS + 1) begin
            run_update(8'd100, 16'sd50, SA_AUTO, SB_UP);
            expect_mode(flight_pkg::MODE_GO_UP);
            check_value("throttle_pwm_val_out", 32'(throttle_pwm_val_out),
                        32'(flight_pkg::LEVEL_CLIMB));
        end
        run_update(8'd100, 16'sd50, SA_AUTO, SB_UP);
        expect_mode(flight_pkg::MODE_IN_AIR);
        check_value("in_air", 32'(in_air), 32'd1);
        check_value("throttle_pwm_val_out", 32'(throttle_pwm_val_out),
                    32'(flight_pkg::LEVEL_HOVER));
        run_update(8'd100, -16'sd50, SA_AUTO, SB_DOWN);
        expect_mode(flight_pkg::MODE_DOWN_START);
        repeat (CLIMB_STEPS + 1) begin
            run_update(8'd100, -16'sd50, SA_AUTO, SB_DOWN);
            expect_mode(flight_pkg::MODE_GO_DOWN);
        end
        run_update(8'd100, -16'sd50, SA_AUTO, SB_DOWN);
        expect_mode(flight_pkg::MODE_ON_GROUND);
        run_update(8'd100, 16'sd0, SA_AUTO, SB_NONE);
        expect_mode(flight_pkg::MODE_GROUND_IDLE);
        check_value("throttle_pwm_val_out", 32'(throttle_pwm_val_out), 32'd0);
        check_value("in_air", 32'(in_air), 32'd0);

        // Throttle cut while climbing, then while hovering
        run_update(8'd5, 16'sd0, SA_AUTO, SB_NONE);
        expect_mode(flight_pkg::MODE_FAILSAFE);
        repeat (3) run_update(8'd100, 16'sd50, SA_AUTO, SB_UP);
        expect_mode(flight_pkg::MODE_GO_UP);
        run_update(8'd5, 16'sd50, SA_AUTO, SB_UP);
        expect_mode(flight_pkg::MODE_FAILSAFE);
        check_value("throttle_pwm_val_out", 32'(throttle_pwm_val_out), 32'd0);
        repeat (CLIMB_STEPS + 4) run_update(8'd100, 16'sd50, SA_AUTO, SB_UP);
        expect_mode(flight_pkg::MODE_IN_AIR);
        run_update(8'd9, 16'sd50, SA_AUTO, SB_NONE);
        expect_mode(flight_pkg::MODE_FAILSAFE);
        check_value("throttle_pwm_val_out", 32'(throttle_pwm_val_out), 32'd0);

        // Manual mode passes the pilot throttle through
        run_update(8'd100, 16'sd50, SA_AUTO, SB_NONE);
        run_update(8'd100, 16'sd50, SA_MANUAL, SB_NONE);
        expect_mode(flight_pkg::MODE_MANUAL);
        foreach (manual_levels[i]) begin
            run_update(manual_levels[i], 16'sd50, SA_MANUAL, SB_UP);
            expect_mode(flight_pkg::MODE_MANUAL);
            check_value("throttle_pwm_val_out", 32'(throttle_pwm_val_out),
                        32'(manual_levels[i]));
        end
        run_update(8'd60, 16'sd50, SA_AUTO, SB_NONE);
        expect_mode(flight_pkg::MODE_IN_AIR);

        // Random updates biased toward the throttle and still limits
        for (int n = 0; n < RANDOM_UPDATES; n++) begin
            if (rand_bits(1) == 16'd1) thr = 8'(rand_bits(4));
            else thr = 8'(rand_bits(8));
            if (rand_bits(1) == 16'd1) vel = flight_pkg::velocity_t'(rand_bits(5)) - 16'sd16;
            else vel = flight_pkg::velocity_t'(rand_bits(16));
            run_update(thr, vel, 3'(rand_bits(3)), 2'(rand_bits(2)));
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hw/flight_pkg.sv
hw/update_sequencer.sv
hw/sample_qualifier.sv
hw/flight_mode_fsm.sv
hw/auto_mode_controller.sv
sim/tb_auto_mode.sv
